// ==== common/dino_pkg.sv ====
`default_nettype none

package dino_pkg;

	typedef logic [8:0] x_t;
	typedef logic [7:0] y_t;
	typedef logic [15:0] score_t;
	typedef logic signed [9:0] vel_t;   // Negative moves up the screen

	// Screen and objects, 320x240
	localparam x_t XSCREEN = 9'd320;
	localparam y_t GROUND_Y = 8'd109;
	localparam x_t DINO_X = 9'd52;
	localparam y_t OBS_Y = 8'd109;
	localparam int OBS_SIZE = 16;
	localparam int OBS_STEP = 4;        // Pixels per frame tick

	localparam vel_t JUMP_SPEED = 10'sd10;
	localparam vel_t GRAVITY = 10'sd1;

	// Dino hitbox inside its 32x32 box
	localparam int DINO_HIT_XOFS = 6;
	localparam int DINO_HIT_W = 20;
	localparam int STAND_TOP = 2;
	localparam int STAND_H = 28;
	localparam int DUCK_TOP = 16;       // Head drops when ducking
	localparam int DUCK_H = 16;

	localparam int RESPAWN_SPAN = 100;

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	typedef enum logic [7:0] {
		CMD_JUMP = 8'h4A,   // ASCII J
		CMD_DUCK = 8'h44,   // ASCII D
		CMD_IDLE = 8'h49    // ASCII I
	} cmd_e;

	typedef enum logic {RUNNING, AIRBORNE} jump_state_e;

endpackage

`default_nettype wire

// ==== dino_runner.f ====
common/dino_pkg.sv
hdl/player_input.sv
uart/uart_rx.sv
uart/cmd_decoder.sv
game/obstacle_motion.sv
game/dino_physics.sv
game/collision_score.sv
hdl/score_display.sv
hdl/dino_runner_top.sv
sim/dino_runner_sva.sv
sim/tb_dino_runner.sv

// ==== game/collision_score.sv ====
`timescale 1ns/1ps
`default_nettype none

module collision_score import dino_pkg::*; (
	input  logic Clock,
	input  logic rst_n,
	input  logic i_restart,
	input  logic i_ducking,
	input  y_t i_dino_y,
	input  x_t i_obs_x,
	output logic o_game_over,
	output logic o_respawn,
	output score_t o_score,
	output score_t o_high_score
);

	localparam x_t START_X = x_t'(XSCREEN - OBS_SIZE);
	localparam int D_LEFT = DINO_X + DINO_HIT_XOFS;
	localparam int D_RIGHT = D_LEFT + DINO_HIT_W;
	localparam int O_BOTTOM = OBS_Y + OBS_SIZE;

	logic [9:0] obs_right;
	logic [8:0] dino_top;
	logic [8:0] dino_bottom;
	logic overlap;
	logic overlap_d;
	logic crossing;
	logic game_over_d;
	x_t obs_x_d;

	// Dino box follows y, obstacle box sits on the ground line
	assign obs_right = {1'b0, i_obs_x} + 10'(OBS_SIZE);
	assign dino_top = {1'b0, i_dino_y} + (i_ducking ? 9'(DUCK_TOP) : 9'(STAND_TOP));
	assign dino_bottom = dino_top + (i_ducking ? 9'(DUCK_H) : 9'(STAND_H));

	assign overlap = (i_obs_x <= x_t'(D_RIGHT)) &&
		(obs_right >= 10'(D_LEFT)) &&
		(dino_bottom >= {1'b0, OBS_Y}) &&
		(dino_top <= 9'(O_BOTTOM));

	assign crossing = (obs_x_d > DINO_X) && (i_obs_x <= DINO_X);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			o_game_over <= 1'b0;
			o_respawn <= 1'b0;
			o_score <= '0;
			o_high_score <= '0;
			overlap_d <= 1'b0;
			game_over_d <= 1'b0;
			obs_x_d <= START_X;
		end else begin
			overlap_d <= overlap;
			game_over_d <= o_game_over;
			obs_x_d <= i_obs_x;
			o_respawn <= 1'b0;
			if (i_restart) begin
				o_game_over <= 1'b0;
				o_score <= '0;
			end else begin
				if (overlap) begin
					o_game_over <= 1'b1;
				end
				// Clean pass, no contact now or a cycle ago
				if (!o_game_over && crossing && !overlap && !overlap_d) begin
					o_score <= o_score + 1'b1;
					o_respawn <= 1'b1;
				end
			end
			if (o_game_over && !game_over_d && o_score > o_high_score) begin
				o_high_score <= o_score;
			end
		end
	end

endmodule

`default_nettype wire

// ==== game/dino_physics.sv ====
`timescale 1ns/1ps
`default_nettype none

module dino_physics import dino_pkg::*; #(
	parameter int DUCK_CYCLES = 25_000_000
) (
	input  logic Clock,
	input  logic rst_n,
	input  logic i_hold,
	input  logic i_frame_tick,
	input  logic i_jump,
	input  logic i_duck,
	output y_t o_dino_y,
	output logic o_ducking
);

	localparam int DUCK_W = $clog2(DUCK_CYCLES + 1);
	localparam logic signed [10:0] GROUND_LIM = 11'(GROUND_Y);

	jump_state_e state;
	vel_t vel;
	logic [DUCK_W-1:0] duck_timer;
	logic signed [10:0] next_y;

	// Where this tick's move would put the dino
	assign next_y = $signed({3'b000, o_dino_y}) + vel;

	always_ff @(posedge Clock) begin
		if (!rst_n || i_hold) begin
			state <= RUNNING;
			vel <= '0;
			o_dino_y <= GROUND_Y;
			o_ducking <= 1'b0;
			duck_timer <= '0;
		end else begin
			// Timed duck, only from the ground
			if (i_duck && state == RUNNING && !o_ducking) begin
				o_ducking <= 1'b1;
				duck_timer <= DUCK_W'(DUCK_CYCLES);
			end else if (duck_timer != '0) begin
				duck_timer <= duck_timer - 1'b1;
			end else begin
				o_ducking <= 1'b0;
			end

			if (i_jump && state == RUNNING && !o_ducking) begin
				state <= AIRBORNE;
				vel <= -JUMP_SPEED;   // Takes effect on the next frame tick
			end else if (i_frame_tick && state == AIRBORNE) begin
				if (next_y >= GROUND_LIM) begin
					o_dino_y <= GROUND_Y;   // Snap to ground
					vel <= '0;
					state <= RUNNING;
				end else begin
					o_dino_y <= next_y[7:0];
					vel <= vel + GRAVITY;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== game/obstacle_motion.sv ====
`timescale 1ns/1ps
`default_nettype none

module obstacle_motion import dino_pkg::*; #(
	parameter int TICK_BITS = 19
) (
	input  logic Clock,
	input  logic rst_n,
	input  logic i_hold,
	input  logic i_respawn,
	output logic o_frame_tick,
	output x_t o_obs_x
);

	localparam x_t START_X = x_t'(XSCREEN - OBS_SIZE);

	logic [TICK_BITS-1:0] tick_cnt;
	logic [15:0] lfsr;
	logic lfsr_fb;
	x_t respawn_x;

	// Free running, one tick per counter wrap
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			o_frame_tick <= 1'b0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
			o_frame_tick <= (tick_cnt == '1);
		end
	end

	assign lfsr_fb = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			lfsr <= 16'hACE1;   // Any nonzero seed
		end else begin
			lfsr <= {lfsr[14:0], lfsr_fb};
		end
	end

	// Somewhere just past the right edge
	assign respawn_x = START_X + x_t'(lfsr[8:0] % RESPAWN_SPAN);

	always_ff @(posedge Clock) begin
		if (!rst_n || i_hold) begin
			o_obs_x <= START_X;
		end else if (i_respawn) begin
			o_obs_x <= respawn_x;
		end else if (o_frame_tick) begin
			if (o_obs_x <= x_t'(OBS_STEP)) begin
				o_obs_x <= START_X;   // Left the screen, wrap
			end else begin
				o_obs_x <= o_obs_x - x_t'(OBS_STEP);
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/dino_runner_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dino_runner_top import dino_pkg::*; #(
	parameter int CLK_HZ = 50_000_000,
	parameter int BAUD = 115_200,
	parameter int TICK_BITS = 19,
	parameter int DUCK_CYCLES = 25_000_000
) (
	input  logic Clock,
	input  logic rst_n,
	input  logic i_rx,
	input  logic i_key_jump,
	input  logic i_key_duck,
	input  logic i_key_restart,
	output y_t o_dino_y,
	output x_t o_obs_x,
	output logic o_ducking,
	output logic o_game_over,
	output score_t o_score,
	output score_t o_high_score,
	output logic [6:0] o_hex0,
	output logic [6:0] o_hex1,
	output logic [6:0] o_hex2,
	output logic [6:0] o_hex3,
	output logic [6:0] o_hex4,
	output logic [6:0] o_hex5
);

	logic rx_valid;
	logic [7:0] rx_byte;
	logic jump_cmd, duck_cmd;
	logic jump, duck, restart;
	logic frame_tick;
	logic respawn;
	wire hold;

	assign hold = o_game_over | restart;   // Freezes both motion blocks

	uart_rx #(.CLK_HZ(CLK_HZ), .BAUD(BAUD)) u_uart_rx (
		.Clock(Clock), .rst_n(rst_n), .i_rx(i_rx),
		.o_rx_valid(rx_valid), .o_rx_byte(rx_byte)
	);

	cmd_decoder u_cmd_decoder (
		.Clock(Clock), .rst_n(rst_n), .i_rx_valid(rx_valid), .i_rx_byte(rx_byte),
		.o_jump_cmd(jump_cmd), .o_duck_cmd(duck_cmd)
	);

	player_input u_player_input (
		.Clock(Clock), .rst_n(rst_n),
		.i_key_jump(i_key_jump), .i_key_duck(i_key_duck), .i_key_restart(i_key_restart),
		.i_jump_cmd(jump_cmd), .i_duck_cmd(duck_cmd),
		.o_jump(jump), .o_duck(duck), .o_restart(restart)
	);

	obstacle_motion #(.TICK_BITS(TICK_BITS)) u_obstacle_motion (
		.Clock(Clock), .rst_n(rst_n), .i_hold(hold), .i_respawn(respawn),
		.o_frame_tick(frame_tick), .o_obs_x(o_obs_x)
	);

	dino_physics #(.DUCK_CYCLES(DUCK_CYCLES)) u_dino_physics (
		.Clock(Clock), .rst_n(rst_n), .i_hold(hold), .i_frame_tick(frame_tick),
		.i_jump(jump), .i_duck(duck),
		.o_dino_y(o_dino_y), .o_ducking(o_ducking)
	);

	collision_score u_collision_score (
		.Clock(Clock), .rst_n(rst_n), .i_restart(restart), .i_ducking(o_ducking),
		.i_dino_y(o_dino_y), .i_obs_x(o_obs_x),
		.o_game_over(o_game_over), .o_respawn(respawn),
		.o_score(o_score), .o_high_score(o_high_score)
	);

	score_display u_score_display (
		.i_score(o_score), .i_high_score(o_high_score),
		.o_hex0(o_hex0), .o_hex1(o_hex1), .o_hex2(o_hex2),
		.o_hex3(o_hex3), .o_hex4(o_hex4), .o_hex5(o_hex5)
	);

endmodule

`default_nettype wire

// ==== hdl/player_input.sv ====
`timescale 1ns/1ps
`default_nettype none

module player_input (
	input  logic Clock,
	input  logic rst_n,
	input  logic i_key_jump,
	input  logic i_key_duck,
	input  logic i_key_restart,
	input  logic i_jump_cmd,
	input  logic i_duck_cmd,
	output logic o_jump,
	output logic o_duck,
	output logic o_restart
);

	logic [1:0] jump_sync;
	logic [1:0] duck_sync;
	logic [1:0] restart_sync;

	// Keys are active low, inverted on the way into the first flop
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			jump_sync <= 2'b00;
			duck_sync <= 2'b00;
			restart_sync <= 2'b00;
		end else begin
			jump_sync <= {jump_sync[0], ~i_key_jump};
			duck_sync <= {duck_sync[0], ~i_key_duck};
			restart_sync <= {restart_sync[0], ~i_key_restart};
		end
	end

	assign o_jump = jump_sync[1] | i_jump_cmd;   // Key or UART
	assign o_duck = duck_sync[1] | i_duck_cmd;
	assign o_restart = restart_sync[1];

endmodule

`default_nettype wire

// ==== hdl/score_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_display import dino_pkg::*; (
	input  score_t i_score,
	input  score_t i_high_score,
	output logic [6:0] o_hex0,
	output logic [6:0] o_hex1,
	output logic [6:0] o_hex2,
	output logic [6:0] o_hex3,
	output logic [6:0] o_hex4,
	output logic [6:0] o_hex5
);

	// Active low segments, g down to a
	function automatic logic [6:0] seg7(input logic [3:0] digit);
		logic [6:0] seg;
		case (digit)
			4'd0: seg = 7'b1000000;
			4'd1: seg = 7'b1111001;
			4'd2: seg = 7'b0100100;
			4'd3: seg = 7'b0110000;
			4'd4: seg = 7'b0011001;
			4'd5: seg = 7'b0010010;
			4'd6: seg = 7'b0000010;
			4'd7: seg = 7'b1111000;
			4'd8: seg = 7'b0000000;
			4'd9: seg = 7'b0010000;
			default: seg = 7'b1111111;   // Blank
		endcase
		return seg;
	endfunction

	function automatic logic [3:0] dec_digit(input score_t value, input int place);
		return 4'((value / place) % 10);
	endfunction

	assign o_hex0 = seg7(dec_digit(i_score, 1));
	assign o_hex1 = seg7(dec_digit(i_score, 10));
	assign o_hex2 = seg7(dec_digit(i_score, 100));
	assign o_hex3 = seg7(dec_digit(i_high_score, 1));   // High score on the left three
	assign o_hex4 = seg7(dec_digit(i_high_score, 10));
	assign o_hex5 = seg7(dec_digit(i_high_score, 100));

endmodule

`default_nettype wire

// ==== sim/dino_runner_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module collision_score_sva import dino_pkg::*; (
	input logic Clock,
	input logic rst_n,
	input logic i_restart,
	input logic o_game_over,
	input score_t o_score,
	input score_t o_high_score
);

	int failures = 0;   // Failed assertions so far

	// Game over is a latch, only restart releases it
	game_over_held: assert property (@(posedge Clock) disable iff (!rst_n)
		o_game_over && !i_restart |=> o_game_over)
		else begin
			$error("game over dropped without restart");
			failures++;
		end

	score_frozen: assert property (@(posedge Clock) disable iff (!rst_n)
		o_game_over && !i_restart |=> $stable(o_score))
		else begin
			$error("score changed during game over");
			failures++;
		end

	score_step: assert property (@(posedge Clock) disable iff (!rst_n)
		!i_restart |=> (o_score == $past(o_score)) || (o_score == $past(o_score) + 1'b1))
		else begin
			$error("score stepped by more than one");
			failures++;
		end

	high_score_monotonic: assert property (@(posedge Clock) disable iff (!rst_n)
		1'b1 |=> o_high_score >= $past(o_high_score))
		else begin
			$error("high score decreased");
			failures++;
		end

endmodule

bind collision_score collision_score_sva u_sva (
	.Clock(Clock), .rst_n(rst_n), .i_restart(i_restart),
	.o_game_over(o_game_over), .o_score(o_score), .o_high_score(o_high_score)
);

`default_nettype wire

// ==== sim/tb_dino_runner.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dino_runner import dino_pkg::*; ;

	localparam int BIT_CLKS = 64;           // 1.6 MHz / 25 kBd
	localparam int DUCK_CYCLES = 200;
	localparam int N_ACTIONS = 120;
	localparam int MAX_GAP = 300;
	localparam int START_X = XSCREEN - OBS_SIZE;
	localparam int PLANNED_CYCLES = 6000 + N_ACTIONS * (10 * BIT_CLKS + MAX_GAP + 120);

	logic Clock = 1'b0;
	logic rst_n;
	logic rx;
	logic key_jump, key_duck, key_restart;
	y_t dino_y;
	x_t obs_x;
	logic ducking, game_over;
	score_t score, high_score;
	logic [6:0] hex0, hex1, hex2, hex3, hex4, hex5;

	int seed = 25;
	int errors = 0;
	int samples = 0;
	int jumps = 0;
	int passes = 0;

	// Model state
	logic rs0, rs1;     // Restart key after its two flops
	logic model_go, go_d, hold_prev, resp_window, scored_d, prev_ov, prev_ducking, airborne;
	int model_score, model_hs, vel, min_y, duck_len;
	int prev_x, prev_y;

	dino_runner_top #(.CLK_HZ(1_600_000), .BAUD(25_000), .TICK_BITS(6),
		.DUCK_CYCLES(DUCK_CYCLES)) uut (
		.Clock(Clock), .rst_n(rst_n), .i_rx(rx),
		.i_key_jump(key_jump), .i_key_duck(key_duck), .i_key_restart(key_restart),
		.o_dino_y(dino_y), .o_obs_x(obs_x), .o_ducking(ducking), .o_game_over(game_over),
		.o_score(score), .o_high_score(high_score),
		.o_hex0(hex0), .o_hex1(hex1), .o_hex2(hex2),
		.o_hex3(hex3), .o_hex4(hex4), .o_hex5(hex5)
	);

	always #50 Clock = ~Clock;

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		errors++;
	endtask

	function automatic logic [6:0] segments_for(input int digit);
		case (digit)
			0: return 7'b1000000;
			1: return 7'b1111001;
			2: return 7'b0100100;
			3: return 7'b0110000;
			4: return 7'b0011001;
			5: return 7'b0010010;
			6: return 7'b0000010;
			7: return 7'b1111000;
			8: return 7'b0000000;
			9: return 7'b0010000;
			default: return 7'b1111111;
		endcase
	endfunction

	function automatic logic [41:0] display_for(input int s, input int hs);
		return {segments_for((hs / 100) % 10), segments_for((hs / 10) % 10),
			segments_for(hs % 10), segments_for((s / 100) % 10),
			segments_for((s / 10) % 10), segments_for(s % 10)};
	endfunction

	// Four-edge box test, dino hitbox shrinks when ducking
	function automatic logic overlap_of(input int y, input int x, input logic duck);
		int top;
		int bottom;
		top = y + (duck ? DUCK_TOP : STAND_TOP);
		bottom = top + (duck ? DUCK_H : STAND_H);
		return (x <= DINO_X + DINO_HIT_XOFS + DINO_HIT_W) &&
			(x + OBS_SIZE >= DINO_X + DINO_HIT_XOFS) &&
			(bottom >= OBS_Y) && (top <= OBS_Y + OBS_SIZE);
	endfunction

	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		@(posedge Clock);
		for (int i = 0; i < 10; i++) begin
			rx <= frame[i];
			repeat (BIT_CLKS) @(posedge Clock);
		end
	endtask

	task automatic press_key(input int which, input int len);
		@(posedge Clock);
		case (which)
			0: key_jump <= 1'b0;
			1: key_duck <= 1'b0;
			default: key_restart <= 1'b0;
		endcase
		repeat (len) @(posedge Clock);
		key_jump <= 1'b1;
		key_duck <= 1'b1;
		key_restart <= 1'b1;
	endtask

	always @(posedge Clock) begin
		if (!rst_n) begin
			rs0 <= 1'b0;
			rs1 <= 1'b0;
		end else begin
			rs0 <= ~key_restart;
			rs1 <= rs0;
		end
	end

	// Sampled on the falling edge where outputs are stable
	always @(negedge Clock) begin : monitor
		logic ov;
		logic scored;
		int v;
		int exp_y;
		if (!rst_n) begin
			model_go = 0;
			go_d = 0;
			hold_prev = 0;
			resp_window = 0;
			scored_d = 0;
			prev_ov = 0;
			prev_ducking = 0;
			airborne = 0;
			model_score = 0;
			model_hs = 0;
			vel = 0;
			min_y = GROUND_Y;
			duck_len = 0;
			prev_x = START_X;
			prev_y = GROUND_Y;
		end else begin
			samples++;
			ov = overlap_of(dino_y, obs_x, ducking);
			assert (game_over == model_go) else report_mismatch("game over mismatch");
			assert (score == model_score)
				else report_mismatch($sformatf("score %0d, expected %0d", score, model_score));
			assert (high_score == model_hs)
				else report_mismatch($sformatf("high score %0d, expected %0d", high_score, model_hs));
			assert ({hex5, hex4, hex3, hex2, hex1, hex0} == display_for(model_score, model_hs))
				else report_mismatch("seven-segment digits wrong");
			if (obs_x != prev_x) begin
				assert (obs_x == prev_x - OBS_STEP ||
					(obs_x == START_X && (prev_x <= OBS_STEP || hold_prev)) ||
					(resp_window && obs_x >= START_X && obs_x < START_X + RESPAWN_SPAN))
					else report_mismatch($sformatf("obstacle moved %0d to %0d", prev_x, obs_x));
			end
			if (model_go && go_d) begin
				assert (dino_y == GROUND_Y && obs_x == START_X && !ducking)
					else report_mismatch("positions not at start during game over");
			end
			if (hold_prev) begin
				airborne = 0;
				assert (dino_y == GROUND_Y) else report_mismatch("dino not grounded by hold");
			end else if (dino_y != prev_y) begin
				if (!airborne) begin
					assert (prev_y == GROUND_Y && dino_y == GROUND_Y - JUMP_SPEED)
						else report_mismatch($sformatf("bad takeoff to y %0d", dino_y));
					assert (duck_len == 0) else report_mismatch("jump started while ducking");
					airborne = 1;
					vel = 1 - JUMP_SPEED;
					min_y = dino_y;
				end else begin
					v = (vel == 0) ? 1 : vel;   // A zero step leaves y unchanged
					exp_y = prev_y + v;
					if (exp_y >= GROUND_Y) exp_y = GROUND_Y;
					assert (dino_y == exp_y)
						else report_mismatch($sformatf("y %0d, expected %0d", dino_y, exp_y));
					vel = v + GRAVITY;
					if (dino_y < min_y) min_y = dino_y;
					if (dino_y == GROUND_Y) begin
						airborne = 0;
						jumps++;
						assert (min_y == GROUND_Y - 55)
							else report_mismatch($sformatf("jump peak %0d", min_y));
					end
				end
			end
			if (ducking) begin
				duck_len++;
			end else begin
				if (prev_ducking && !hold_prev) begin
					assert (duck_len == DUCK_CYCLES + 1)
						else report_mismatch($sformatf("duck lasted %0d cycles", duck_len));
				end
				duck_len = 0;
			end
			scored = !rs1 && !model_go && prev_x > DINO_X && obs_x <= DINO_X && !ov && !prev_ov;
			if (scored) passes++;
			if (model_go && !go_d && model_score > model_hs) model_hs = model_score;
			hold_prev = model_go | rs1;
			go_d = model_go;
			model_go = rs1 ? 1'b0 : (model_go | ov);
			model_score = rs1 ? 0 : (scored ? model_score + 1 : model_score);
			resp_window = scored_d;
			scored_d = scored;
			prev_ov = ov;
			prev_x = obs_x;
			prev_y = dino_y;
			prev_ducking = ducking;
		end
	end

	initial begin : watchdog
		#(PLANNED_CYCLES * 150);
		$display("Timeout: run did not finish within %0d cycles", PLANNED_CYCLES * 3 / 2);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : stimulus
		int errors_before;
		int k;
		int r;
		int sva_failures;
		rst_n = 1'b0;
		rx = 1'b1;
		key_jump = 1'b1;
		key_duck = 1'b1;
		key_restart = 1'b1;
		repeat (16) @(posedge Clock);
		rst_n <= 1'b1;

		// Directed command bytes
		errors_before = errors;
		send_byte(CMD_IDLE);
		repeat (100) @(posedge Clock);
		assert (dino_y == GROUND_Y && !ducking) else report_mismatch("idle byte moved the dino");
		send_byte(8'h58);
		repeat (100) @(posedge Clock);
		assert (dino_y == GROUND_Y && !ducking) else report_mismatch("unknown byte moved the dino");
		// Restart pulse puts the obstacle back at the right edge
		key_restart <= 1'b0;
		repeat (6) @(posedge Clock);
		key_restart <= 1'b1;
		repeat (6) @(posedge Clock);
		send_byte(CMD_JUMP);
		for (k = 0; k < 3 * BIT_CLKS && dino_y == GROUND_Y; k++) @(negedge Clock);
		assert (dino_y != GROUND_Y) else report_mismatch("jump byte did not start a jump");
		for (k = 0; k < 3000 && dino_y != GROUND_Y; k++) @(negedge Clock);
		send_byte(CMD_DUCK);
		for (k = 0; k < 3 * BIT_CLKS && !ducking; k++) @(negedge Clock);
		assert (ducking) else report_mismatch("duck byte did not raise ducking");
		for (k = 0; k < 2 * DUCK_CYCLES && ducking; k++) @(negedge Clock);
		$display("TEST commands: %0d errors", errors - errors_before);

		// Random play with a restart after each game over
		errors_before = errors;
		for (int a = 0; a < N_ACTIONS; a++) begin
			if (game_over) begin
				repeat (20 + $unsigned($random(seed)) % 60) @(posedge Clock);
				press_key(2, 6);
				repeat (4) @(posedge Clock);
			end
			r = $unsigned($random(seed)) % 100;
			if (r < 60) send_byte(CMD_JUMP);
			else if (r < 70) send_byte(CMD_DUCK);
			else if (r < 78) send_byte(CMD_IDLE);
			else if (r < 85) send_byte(8'($random(seed)));
			else if (r < 93) press_key(0, 3 + $unsigned($random(seed)) % 8);
			else press_key(1, 3 + $unsigned($random(seed)) % 8);
			repeat ($unsigned($random(seed)) % MAX_GAP) @(posedge Clock);
		end
		$display("TEST random play: %0d errors, %0d jumps, %0d passes",
			errors - errors_before, jumps, passes);

		sva_failures = uut.u_collision_score.u_sva.failures;
		$display("Summary: %0d samples checked, %0d errors, %0d assertion failures",
			samples, errors, sva_failures);
		if (errors == 0 && sva_failures == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== uart/cmd_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder import dino_pkg::*; (
	input  logic Clock,
	input  logic rst_n,
	input  logic i_rx_valid,
	input  logic [7:0] i_rx_byte,
	output logic o_jump_cmd,
	output logic o_duck_cmd
);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			o_jump_cmd <= 1'b0;
			o_duck_cmd <= 1'b0;
		end else begin
			o_jump_cmd <= 1'b0;
			o_duck_cmd <= 1'b0;
			if (i_rx_valid) begin
				case (i_rx_byte)
					CMD_JUMP: o_jump_cmd <= 1'b1;
					CMD_DUCK: o_duck_cmd <= 1'b1;
					CMD_IDLE: ;   // Accepted but does nothing in the game core
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== uart/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx import dino_pkg::*; #(
	parameter int CLK_HZ = 50_000_000,
	parameter int BAUD = 115_200
) (
	input  logic Clock,
	input  logic rst_n,
	input  logic i_rx,
	output logic o_rx_valid,
	output logic [7:0] o_rx_byte
);

	localparam int DIV = CLK_HZ / (BAUD * 16);
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0] div_cnt;
	logic os_tick;
	logic rx_meta;
	logic rx_sync;
	rx_state_e state;
	logic [3:0] os_cnt;     // Oversample ticks left in the current bit
	logic [2:0] bit_idx;
	logic [7:0] shift;

	// 16x baud tick
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			div_cnt <= '0;
			os_tick <= 1'b0;
		end else if (div_cnt == CNT_W'(DIV - 1)) begin
			div_cnt <= '0;
			os_tick <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			os_tick <= 1'b0;
		end
	end

	// Line idles high
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= i_rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			os_cnt <= 4'd0;
			bit_idx <= 3'd0;
			o_rx_valid <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0;
			if (os_tick) begin
				if (os_cnt != 4'd0) begin
					os_cnt <= os_cnt - 1'b1;
				end else begin
					case (state)
						RX_IDLE: begin
							if (!rx_sync) begin
								state <= RX_START;
								os_cnt <= 4'd7;   // Wait to mid start bit
							end
						end
						RX_START: begin
							if (!rx_sync) begin
								state <= RX_DATA;
								os_cnt <= 4'd15;
								bit_idx <= 3'd0;
							end else begin
								state <= RX_IDLE;   // Glitch, not a start bit
							end
						end
						RX_DATA: begin
							os_cnt <= 4'd15;
							if (bit_idx == 3'd7) begin
								state <= RX_STOP;
							end else begin
								bit_idx <= bit_idx + 1'b1;
							end
						end
						RX_STOP: begin
							o_rx_valid <= rx_sync;   // Framing error drops the byte
							state <= RX_IDLE;
						end
						default: state <= RX_IDLE;
					endcase
				end
			end
		end
	end

	// LSB first
	always_ff @(posedge Clock) begin
		if (os_tick && os_cnt == 4'd0) begin
			if (state == RX_DATA) begin
				shift[bit_idx] <= rx_sync;
			end
			if (state == RX_STOP) begin
				o_rx_byte <= shift;
			end
		end
	end

endmodule

`default_nettype wire
